/* list.f */
+incdir+hw
hw/vector_unit_pkg.sv
hw/vector_bus_pkg.sv
hw/vector_comparison_unit.sv
hw/vector_wb_frontend.sv
hw/vector_request_fifo.sv
hw/vector_compare_stage.sv
hw/vector_compare_top.sv
test/vector_compare_properties.sv
test/tb_vector_compare_top.sv

/* Bender.yml */
package:
  name: vector_compare

sources:
  - include_dirs:
      - hw
    files:
      - hw/vector_unit_pkg.sv
      - hw/vector_bus_pkg.sv
      - hw/vector_comparison_unit.sv
      - hw/vector_wb_frontend.sv
      - hw/vector_request_fifo.sv
      - hw/vector_compare_stage.sv
      - hw/vector_compare_top.sv
  - target: test
    include_dirs:
      - hw
    files:
      - test/vector_compare_properties.sv
      - test/tb_vector_compare_top.sv

/* test/tb_vector_compare_top.sv */
// Directed testbench for the compare accelerator with reference model, LFSR and checks

`timescale 1ns/10ps

`include "vector_unit_consts.svh"

module tb_vector_compare_top;

    import vector_unit_pkg::*;
    import vector_bus_pkg::*;

    localparam int ACK_TIMEOUT  = 20;
    localparam int POLL_LIMIT   = 20;
    localparam int STALL_CYCLES = 8;

    logic        clk_i;
    logic        rst_n_i;
    wb_req_t     wb_req;
    wb_rsp_t     wb_rsp;
    logic [31:0] lfsr_state;
    int          mismatch_errors;
    int          timeout_errors;
    int          other_errors;
    // Expected results in issue order for the back-pressure test
    vector_t     expected_q[$];

    vector_compare_top i_dut (
        .clk_i    (clk_i),
        .rst_n_i  (rst_n_i),
        .wb_req_i (wb_req),
        .wb_rsp_o (wb_rsp)
    );

    always #2 clk_i = ~clk_i;

    // ------------------------------
    // Stimulus helpers
    // ------------------------------

    // 32 bit Fibonacci LFSR with taps 32, 22, 2 and 1
    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    // One LFSR step per bit of the returned word
    function automatic logic [31:0] rand_word();
        logic [31:0] w;
        for (int i = 0; i < 32; i++) begin
            lfsr_state = lfsr_step(lfsr_state);
            w[i] = lfsr_state[0];
        end
        return w;
    endfunction

    function automatic logic [31:0] cmd_word(input logic [2:0] op, input esize_t es,
                                             input logic sgn);
        logic [31:0] w;
        w = '0;
        w[`VU_CMD_OP_LSB +: 3]   = op;
        w[`VU_CMD_ESIZE_BIT]     = es;
        w[`VU_CMD_SIGNED_BIT]    = sgn;
        return w;
    endfunction

    function automatic logic [31:0] status_word(input logic valid, input logic full,
                                                input int count);
        return {27'd0, 3'(count), full, valid};
    endfunction

    // Expected result straight from the element rules
    // Each element is turned into an integer, negative only in signed mode
    function automatic vector_t model_compare(input vector_t a, input vector_t b,
                                              input logic [2:0] op, input esize_t es,
                                              input logic sgn);
        int          w;
        int          ea;
        int          eb;
        logic [31:0] av;
        logic [31:0] bv;
        logic [31:0] mask;
        logic [31:0] raw_a;
        logic [31:0] raw_b;
        logic [31:0] lane;
        logic [31:0] res;
        w    = (es == BIT16) ? 16 : 8;
        mask = (32'd1 << w) - 1;
        av   = a;
        bv   = b;
        res  = '0;
        for (int i = 0; i < `VU_DATA_WIDTH / w; i++) begin
            raw_a = (av >> (i * w)) & mask;
            raw_b = (bv >> (i * w)) & mask;
            ea = int'(raw_a);
            eb = int'(raw_b);
            if (sgn && raw_a[w-1]) ea = ea - (1 << w);
            if (sgn && raw_b[w-1]) eb = eb - (1 << w);
            case (op)
                VLS:     lane = (ea < eb) ? mask : '0;
                VLS_VEQ: lane = (ea <= eb) ? mask : '0;
                VMIN:    lane = (ea < eb) ? raw_a : raw_b;
                VMAX:    lane = (ea > eb) ? raw_a : raw_b;
                // VEQ and the undefined codes
                default: lane = (ea == eb) ? mask : '0;
            endcase
            res = res | (lane << (i * w));
        end
        return vector_t'(res);
    endfunction

    // ------------------------------
    // Bus tasks
    // ------------------------------

    // One classic cycle, request driven on the edge and ack sampled on later edges
    task automatic bus_cycle(input logic we, input vu_reg_e adr, input logic [31:0] wdat,
                             output logic [31:0] rdat);
        int   cycles;
        logic got;
        got  = 1'b0;
        rdat = '0;
        @(posedge clk_i);
        wb_req.cyc <= 1'b1;
        wb_req.stb <= 1'b1;
        wb_req.we  <= we;
        wb_req.adr <= adr;
        wb_req.dat <= wdat;
        for (cycles = 0; cycles < ACK_TIMEOUT; cycles++) begin
            @(posedge clk_i);
            if (wb_rsp.ack) begin
                got  = 1'b1;
                rdat = wb_rsp.dat;
                break;
            end
        end
        wb_req.cyc <= 1'b0;
        wb_req.stb <= 1'b0;
        wb_req.we  <= 1'b0;
        if (!got) begin
            timeout_errors++;
            $display("Timeout: no ack for access to %s", adr.name());
        end else if (cycles != 1) begin
            // Every access made here finds room in the FIFO, so each acks after one cycle
            other_errors++;
            $display("Ack for access to %s came %0d cycles late", adr.name(), cycles - 1);
        end
    endtask

    task automatic wb_write(input vu_reg_e adr, input logic [31:0] dat);
        logic [31:0] unused;
        bus_cycle(1'b1, adr, dat, unused);
    endtask

    task automatic wb_read(input vu_reg_e adr, output logic [31:0] dat);
        bus_cycle(1'b0, adr, '0, dat);
    endtask

    // ------------------------------
    // Checks
    // ------------------------------

    task automatic check_vector(input string name, input vector_t expected,
                                input vector_t actual);
        if (actual !== expected) begin
            mismatch_errors++;
            $display("[FAIL] %s: expected %h, actual %h", name, expected, actual);
        end
    endtask

    task automatic check_status(input string name, input logic [31:0] expected,
                                input logic [31:0] actual);
        if (actual !== expected) begin
            mismatch_errors++;
            $display("[FAIL] %s: expected status %h, actual %h", name, expected, actual);
        end
    endtask

    // Polls status bit 0, then reads and takes the result
    task automatic fetch_result(input string name, output vector_t result);
        logic [31:0] st;
        logic        seen;
        logic [31:0] rd;
        seen = 1'b0;
        for (int n = 0; n < POLL_LIMIT; n++) begin
            wb_read(REG_STATUS, st);
            if (st[0]) begin
                seen = 1'b1;
                break;
            end
        end
        if (!seen) begin
            timeout_errors++;
            $display("Timeout: result never became valid in %s", name);
        end
        wb_read(REG_RESULT, rd);
        result = vector_t'(rd);
    endtask

    task automatic issue_compare(input vector_t a, input vector_t b, input logic [2:0] op,
                                 input esize_t es, input logic sgn);
        wb_write(REG_OPERAND_A, a);
        wb_write(REG_OPERAND_B, b);
        wb_write(REG_COMMAND, cmd_word(op, es, sgn));
    endtask

    task automatic run_compare(input string name, input vector_t a, input vector_t b,
                               input logic [2:0] op, input esize_t es, input logic sgn,
                               output vector_t actual);
        issue_compare(a, b, op, es, sgn);
        fetch_result(name, actual);
        check_vector(name, model_compare(a, b, op, es, sgn), actual);
    endtask

    // ------------------------------
    // Directed tests
    // ------------------------------

    task automatic test_reset();
        logic [31:0] rd;
        wb_read(REG_STATUS, rd);
        check_status("reset status", 32'd0, rd);
        wb_read(REG_RESULT, rd);
        check_vector("reset result", vector_t'(32'd0), vector_t'(rd));
    endtask

    // Every opcode at one element size, operands from the LFSR
    task automatic test_random_ops(input esize_t es);
        vector_t a;
        vector_t b;
        vector_t act;
        for (int sgn = 0; sgn < 2; sgn++) begin
            for (int op = 0; op < 5; op++) begin
                a = rand_word();
                b = rand_word();
                // Low element is forced equal so the equal path is hit too
                if (es == BIT16) begin
                    b.vect2[0] = a.vect2[0];
                end else begin
                    b.vect4[0] = a.vect4[0];
                end
                run_compare($sformatf("%s op%0d sgn%0d", es.name(), op, sgn),
                            a, b, 3'(op), es, 1'(sgn), act);
            end
        end
    endtask

    task automatic test_half_sign();
        vector_t unsigned_res;
        vector_t signed_res;
        // Upper halves differ in sign, lower halves match
        run_compare("BIT16 less unsigned", 32'h80ff_1234, 32'h7f00_1234, VLS, BIT16, 1'b0,
                    unsigned_res);
        run_compare("BIT16 less signed", 32'h80ff_1234, 32'h7f00_1234, VLS, BIT16, 1'b1,
                    signed_res);
        if (unsigned_res === signed_res) begin
            other_errors++;
            $display("Signed and unsigned 16 bit compares gave the same result %h",
                     signed_res);
        end
    endtask

    task automatic test_edge_ops();
        vector_t act;
        run_compare("BIT16 min equal high", 32'h1234_5678, 32'h1234_0009, VMIN, BIT16, 1'b1,
                    act);
        run_compare("BIT16 max equal high", 32'h1234_5678, 32'h1234_0009, VMAX, BIT16, 1'b0,
                    act);
        run_compare("BIT8 min signed", 32'h1122_3344, 32'h1122_ff00, VMIN, BIT8, 1'b1, act);
        run_compare("BIT8 max signed", 32'h1122_3344, 32'h1122_ff00, VMAX, BIT8, 1'b1, act);
        // Undefined opcodes must match a plain equal compare
        for (int op = 5; op < 8; op++) begin
            issue_compare(32'h00ab_12cd, 32'h00ab_34cd, 3'(op), BIT8, 1'b0);
            fetch_result($sformatf("undefined op%0d", op), act);
            check_vector($sformatf("undefined op%0d", op),
                         model_compare(32'h00ab_12cd, 32'h00ab_34cd, VEQ, BIT8, 1'b0), act);
        end
    endtask

    task automatic test_backpressure();
        vector_t     a;
        vector_t     b;
        vector_t     act;
        logic [31:0] rd;
        logic [31:0] cmd6;
        logic        early;
        // FIFO plus result slot take one more than the FIFO depth
        for (int k = 0; k <= `VU_FIFO_DEPTH; k++) begin
            a = rand_word();
            b = rand_word();
            issue_compare(a, b, 3'(k % 5), esize_t'(k[0]), k[1]);
            expected_q.push_back(model_compare(a, b, 3'(k % 5), esize_t'(k[0]), k[1]));
        end
        wb_read(REG_STATUS, rd);
        check_status("backpressure status", status_word(1'b1, 1'b1, `VU_FIFO_DEPTH), rd);
        a    = rand_word();
        b    = rand_word();
        cmd6 = cmd_word(VLS_VEQ, BIT8, 1'b1);
        expected_q.push_back(model_compare(a, b, VLS_VEQ, BIT8, 1'b1));
        wb_write(REG_OPERAND_A, a);
        wb_write(REG_OPERAND_B, b);
        // The sixth command is held for a window and then abandoned
        early = 1'b0;
        @(posedge clk_i);
        wb_req.cyc <= 1'b1;
        wb_req.stb <= 1'b1;
        wb_req.we  <= 1'b1;
        wb_req.adr <= REG_COMMAND;
        wb_req.dat <= cmd6;
        repeat (STALL_CYCLES) begin
            @(posedge clk_i);
            if (wb_rsp.ack) early = 1'b1;
        end
        wb_req.cyc <= 1'b0;
        wb_req.stb <= 1'b0;
        wb_req.we  <= 1'b0;
        if (early) begin
            other_errors++;
            $display("Command write was acked while the FIFO was full");
        end
        // Reading one result frees a FIFO entry, after which the command goes through
        wb_read(REG_RESULT, rd);
        check_vector("backpressure result 0", expected_q.pop_front(), vector_t'(rd));
        wb_write(REG_COMMAND, cmd6);
        for (int k = 1; k <= `VU_FIFO_DEPTH + 1; k++) begin
            fetch_result($sformatf("backpressure result %0d", k), act);
            check_vector($sformatf("backpressure result %0d", k), expected_q.pop_front(), act);
        end
    endtask

    // ------------------------------
    // Main sequence
    // ------------------------------

    initial begin
        clk_i           = 1'b0;
        rst_n_i         = 1'b0;
        wb_req          = '0;
        lfsr_state      = 32'hd8a2_c844;
        mismatch_errors = 0;
        timeout_errors  = 0;
        other_errors    = 0;
        repeat (3) @(posedge clk_i);
        rst_n_i <= 1'b1;

        test_reset();
        test_random_ops(BIT8);
        test_random_ops(BIT16);
        test_half_sign();
        test_edge_ops();
        test_backpressure();

        repeat (4) @(posedge clk_i);
        $display("Summary: %0d mismatches, %0d timeouts, %0d other errors, %0d assertion failures",
                 mismatch_errors, timeout_errors, other_errors,
                 i_dut.i_properties.failures);
        if (mismatch_errors == 0 && timeout_errors == 0 && other_errors == 0 &&
            i_dut.i_properties.failures == 0) begin
            $display("Verification passed");
        end else begin
            $display("Verification failed");
        end
        $finish;
    end

endmodule : tb_vector_compare_top

/* test/vector_compare_properties.sv */
// Bound concurrent assertions on the Wishbone handshake and the request FIFO push

`timescale 1ns/10ps

module vector_compare_properties (
    input logic                    clk_i,
    input logic                    rst_n_i,
    input vector_bus_pkg::wb_req_t wb_req_i,
    input vector_bus_pkg::wb_rsp_t wb_rsp_i,
    input logic                    push_i,
    input logic                    full_i
);

    // Number of assertion failures, read by the testbench for its summary
    int unsigned failures = 0;

    // ------------------------------
    // Bus handshake
    // ------------------------------

    // Ack only answers a live cycle
    ack_in_cycle: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        wb_rsp_i.ack |-> (wb_req_i.cyc && wb_req_i.stb))
    else begin
        $error("ack raised without cyc and stb");
        failures++;
    end

    // Classic slave acks for a single cycle
    ack_single: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        wb_rsp_i.ack |=> !wb_rsp_i.ack)
    else begin
        $error("ack high in two consecutive cycles");
        failures++;
    end

    // Reset is synchronous, so the cycle after a reset cycle has no ack
    ack_after_reset: assert property (@(posedge clk_i)
        !rst_n_i |=> !wb_rsp_i.ack)
    else begin
        $error("ack high in the cycle after reset");
        failures++;
    end

    // ------------------------------
    // FIFO handshake
    // ------------------------------

    push_not_full: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        push_i |-> !full_i)
    else begin
        $error("push while the request FIFO is full");
        failures++;
    end

endmodule : vector_compare_properties

bind vector_compare_top vector_compare_properties i_properties (
    .clk_i    (clk_i),
    .rst_n_i  (rst_n_i),
    .wb_req_i (wb_req_i),
    .wb_rsp_i (wb_rsp_o),
    .push_i   (push),
    .full_i   (full)
);

/* hw/vector_compare_top.sv */
// Top level of the memory-mapped compare accelerator

`timescale 1ns/10ps

`include "vector_unit_consts.svh"

module vector_compare_top (
    input  logic                     clk_i,
    input  logic                     rst_n_i,
    input  vector_bus_pkg::wb_req_t  wb_req_i,
    output vector_bus_pkg::wb_rsp_t  wb_rsp_o
);

    import vector_unit_pkg::*;

    localparam int CNT_W = $clog2(`VU_FIFO_DEPTH + 1);

    // Front end to FIFO
    logic             push;
    vcomp_req_t       push_data;
    logic             full;
    logic [CNT_W-1:0] count;
    // FIFO to compare stage
    logic             pop;
    vcomp_req_t       pop_data;
    logic             empty;
    // Compare stage to front end
    vector_t          result;
    logic             result_valid;
    logic             result_take;

    // ------------------------------
    // Producer, buffer, consumer
    // ------------------------------

    vector_wb_frontend i_frontend (
        .clk_i          (clk_i),
        .rst_n_i        (rst_n_i),
        .wb_req_i       (wb_req_i),
        .wb_rsp_o       (wb_rsp_o),
        .push_o         (push),
        .push_data_o    (push_data),
        .full_i         (full),
        .count_i        (count),
        .result_i       (result),
        .result_valid_i (result_valid),
        .result_take_o  (result_take)
    );

    vector_request_fifo #(
        .DEPTH (`VU_FIFO_DEPTH)
    ) i_fifo (
        .clk_i       (clk_i),
        .rst_n_i     (rst_n_i),
        .push_i      (push),
        .push_data_i (push_data),
        .pop_i       (pop),
        .pop_data_o  (pop_data),
        .empty_o     (empty),
        .full_o      (full),
        .count_o     (count)
    );

    vector_compare_stage i_stage (
        .clk_i          (clk_i),
        .rst_n_i        (rst_n_i),
        .req_i          (pop_data),
        .empty_i        (empty),
        .pop_o          (pop),
        .result_o       (result),
        .result_valid_o (result_valid),
        .result_take_i  (result_take)
    );

endmodule : vector_compare_top

/* hw/vector_compare_stage.sv */
// Compare stage that pops requests and holds one result for the bus

`timescale 1ns/10ps

module vector_compare_stage (
    input  logic                         clk_i,
    input  logic                         rst_n_i,
    // FIFO head
    input  vector_unit_pkg::vcomp_req_t  req_i,
    input  logic                         empty_i,
    output logic                         pop_o,
    // Result slot
    output vector_unit_pkg::vector_t     result_o,
    output logic                         result_valid_o,
    input  logic                         result_take_i
);

    import vector_unit_pkg::*;

    vector_t unit_result;
    logic    unit_valid;
    vector_t result_q;
    logic    result_valid_q;

    // ------------------------------
    // Pop control
    // ------------------------------

    // The slot can accept a new result when empty or when it empties this cycle
    assign pop_o = ~empty_i & (~result_valid_q | result_take_i);

    // The FIFO head goes straight into the unit and valid marks a real pop
    vector_comparison_unit i_comparison_unit (
        .operand_A_i        (req_i.operand_a),
        .operand_B_i        (req_i.operand_b),
        .element_size_i     (req_i.element_size),
        .operation_i        (req_i.operation),
        .signed_operation_i (req_i.signed_op),
        .data_valid_i       (pop_o),
        .result_o           (unit_result),
        .data_valid_o       (unit_valid)
    );

    // ------------------------------
    // Result slot
    // ------------------------------

    always_ff @(posedge clk_i) begin
        if (unit_valid) begin
            result_q <= unit_result;
        end
    end

    // A new result wins over a take in the same cycle
    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            result_valid_q <= 1'b0;
        end else if (unit_valid) begin
            result_valid_q <= 1'b1;
        end else if (result_take_i) begin
            result_valid_q <= 1'b0;
        end
    end

    assign result_o       = result_q;
    assign result_valid_o = result_valid_q;

endmodule : vector_compare_stage

/* hw/vector_request_fifo.sv */
// Synchronous circular FIFO for compare requests

`timescale 1ns/10ps

module vector_request_fifo #(
    parameter int DEPTH = 4
) (
    input  logic                          clk_i,
    input  logic                          rst_n_i,
    // Write side
    input  logic                          push_i,
    input  vector_unit_pkg::vcomp_req_t   push_data_i,
    // Read side
    input  logic                          pop_i,
    output vector_unit_pkg::vcomp_req_t   pop_data_o,
    // Fill state
    output logic                          empty_o,
    output logic                          full_o,
    output logic [$clog2(DEPTH+1)-1:0]    count_o
);

    import vector_unit_pkg::*;

    localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;

    vcomp_req_t                 mem [DEPTH];
    logic [PTR_W-1:0]           wr_ptr_q;
    logic [PTR_W-1:0]           rd_ptr_q;
    logic [$clog2(DEPTH+1)-1:0] count_q;
    logic                       do_push;
    logic                       do_pop;

    // Requests past a full or empty boundary are dropped
    assign do_push = push_i & ~full_o;
    assign do_pop  = pop_i & ~empty_o;

    // ------------------------------
    // Storage
    // ------------------------------

    always_ff @(posedge clk_i) begin
        if (do_push) begin
            mem[wr_ptr_q] <= push_data_i;
        end
    end

    assign pop_data_o = mem[rd_ptr_q];

    // Pointers wrap at DEPTH so any depth works
    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
            count_q  <= '0;
        end else begin
            if (do_push) begin
                wr_ptr_q <= (wr_ptr_q == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr_q + 1'b1;
            end
            if (do_pop) begin
                rd_ptr_q <= (rd_ptr_q == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr_q + 1'b1;
            end
            // Simultaneous push and pop leave the count alone
            if (do_push && !do_pop) begin
                count_q <= count_q + 1'b1;
            end else if (do_pop && !do_push) begin
                count_q <= count_q - 1'b1;
            end
        end
    end

    assign count_o = count_q;
    assign empty_o = (count_q == '0);
    assign full_o  = (count_q == ($clog2(DEPTH+1))'(DEPTH));

endmodule : vector_request_fifo

/* hw/vector_wb_frontend.sv */
// Wishbone classic slave with operand registers, command decode and status readout

`timescale 1ns/10ps

`include "vector_unit_consts.svh"

module vector_wb_frontend (
    input  logic                         clk_i,
    input  logic                         rst_n_i,
    // Wishbone classic slave port
    input  vector_bus_pkg::wb_req_t      wb_req_i,
    output vector_bus_pkg::wb_rsp_t      wb_rsp_o,
    // Request FIFO side
    output logic                         push_o,
    output vector_unit_pkg::vcomp_req_t  push_data_o,
    input  logic                         full_i,
    input  logic [2:0]                   count_i,
    // Result slot side
    input  vector_unit_pkg::vector_t     result_i,
    input  logic                         result_valid_i,
    output logic                         result_take_o
);

    import vector_unit_pkg::*;
    import vector_bus_pkg::*;

    typedef enum logic {
        IDLE,
        ACK
    } state_e;

    state_e                    state_q;
    state_e                    state_d;
    vu_reg_e                   reg_sel;
    logic                      access;
    logic                      cmd_write;
    logic                      ack;
    vector_t                   operand_a_q;
    vector_t                   operand_b_q;
    logic [`VU_DATA_WIDTH-1:0] status_word;
    logic [`VU_DATA_WIDTH-1:0] read_data;

    // ------------------------------
    // Bus handshake
    // ------------------------------

    assign reg_sel   = vu_reg_e'(wb_req_i.adr);
    assign access    = wb_req_i.cyc & wb_req_i.stb;
    assign cmd_write = access & wb_req_i.we & (reg_sel == REG_COMMAND);

    // A command write waits in IDLE until the FIFO has room
    always_comb begin
        state_d = state_q;
        case (state_q)
            IDLE: begin
                if (access && !(cmd_write && full_i)) begin
                    state_d = ACK;
                end
            end
            default: begin
                state_d = IDLE;
            end
        endcase
    end

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            state_q <= IDLE;
        end else begin
            state_q <= state_d;
        end
    end

    // Ack is high for the single cycle spent in ACK
    assign ack = (state_q == ACK);

    // Operand writes land in the ack cycle
    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            operand_a_q <= '0;
            operand_b_q <= '0;
        end else if (ack && wb_req_i.we) begin
            if (reg_sel == REG_OPERAND_A) begin
                operand_a_q <= wb_req_i.dat;
            end
            if (reg_sel == REG_OPERAND_B) begin
                operand_b_q <= wb_req_i.dat;
            end
        end
    end

    // ------------------------------
    // Command decode and push
    // ------------------------------

    assign push_o = ack & cmd_write;

    always_comb begin
        push_data_o.operand_a    = operand_a_q;
        push_data_o.operand_b    = operand_b_q;
        push_data_o.operation    =
            vcomp_operation_t'(wb_req_i.dat[`VU_CMD_OP_LSB +: 3]);
        push_data_o.element_size = esize_t'(wb_req_i.dat[`VU_CMD_ESIZE_BIT]);
        push_data_o.signed_op    = wb_req_i.dat[`VU_CMD_SIGNED_BIT];
    end

    // ------------------------------
    // Readout
    // ------------------------------

    // Valid in bit 0, full in bit 1 and the FIFO count above them
    always_comb begin
        status_word      = '0;
        status_word[0]   = result_valid_i;
        status_word[1]   = full_i;
        status_word[4:2] = count_i;
    end

    always_comb begin
        case (reg_sel)
            REG_OPERAND_A: read_data = operand_a_q;
            REG_OPERAND_B: read_data = operand_b_q;
            REG_RESULT:    read_data = result_valid_i ? result_i : '0;
            REG_STATUS:    read_data = status_word;
            default:       read_data = '0;
        endcase
    end

    // A result read frees the slot only when it actually returned a result
    assign result_take_o = ack & ~wb_req_i.we & (reg_sel == REG_RESULT) & result_valid_i;

    always_comb begin
        wb_rsp_o.ack = ack;
        wb_rsp_o.dat = (ack && !wb_req_i.we) ? read_data : '0;
    end

endmodule : vector_wb_frontend

/* hw/vector_comparison_unit.sv */
// Combinational SIMD compare unit with equal, less, less or equal, minimum and maximum

`timescale 1ns/10ps

module vector_comparison_unit (
    // Operands
    input  vector_unit_pkg::vector_t          operand_A_i,
    input  vector_unit_pkg::vector_t          operand_B_i,
    // Element size and operation select
    input  vector_unit_pkg::esize_t           element_size_i,
    input  vector_unit_pkg::vcomp_operation_t operation_i,
    input  logic                              signed_operation_i,
    input  logic                              data_valid_i,
    // Result
    output vector_unit_pkg::vector_t          result_o,
    output logic                              data_valid_o
);

    import vector_unit_pkg::*;

    // Per element masks, each element all ones or all zeros
    vector_t eq_mask;
    vector_t lt_mask;
    vector_t gt_mask;

    // Extends an element to 17 bits so one signed compare covers both modes
    // A byte element sits in the low 8 bits of value
    function automatic logic [16:0] extend_elem(
        input logic [15:0] value,
        input esize_t      size,
        input logic        sgn
    );
        logic sign_bit;
        sign_bit = sgn & ((size == BIT16) ? value[15] : value[7]);
        if (size == BIT16) begin
            return {sign_bit, value};
        end
        return {{9{sign_bit}}, value[7:0]};
    endfunction

    // ------------------------------
    // Compare masks
    // ------------------------------

    always_comb begin : mask_logic
        logic [16:0] a_ext;
        logic [16:0] b_ext;
        eq_mask = '0;
        lt_mask = '0;
        gt_mask = '0;
        if (element_size_i == BIT16) begin
            for (int i = 0; i < 2; i++) begin
                a_ext = extend_elem(operand_A_i.vect2[i], BIT16, signed_operation_i);
                b_ext = extend_elem(operand_B_i.vect2[i], BIT16, signed_operation_i);
                eq_mask.vect2[i] = {16{a_ext == b_ext}};
                lt_mask.vect2[i] = {16{$signed(a_ext) < $signed(b_ext)}};
                gt_mask.vect2[i] = {16{$signed(a_ext) > $signed(b_ext)}};
            end
        end else begin
            for (int i = 0; i < 4; i++) begin
                a_ext = extend_elem({8'h00, operand_A_i.vect4[i]}, BIT8, signed_operation_i);
                b_ext = extend_elem({8'h00, operand_B_i.vect4[i]}, BIT8, signed_operation_i);
                eq_mask.vect4[i] = {8{a_ext == b_ext}};
                lt_mask.vect4[i] = {8{$signed(a_ext) < $signed(b_ext)}};
                gt_mask.vect4[i] = {8{$signed(a_ext) > $signed(b_ext)}};
            end
        end
    end : mask_logic

    // ------------------------------
    // Result select
    // ------------------------------

    // Masks are uniform per element, so a bitwise mux picks whole elements
    // for minimum and maximum at either element size
    always_comb begin : result_logic
        case (operation_i)
            VEQ: begin
                result_o = eq_mask;
            end
            VLS: begin
                result_o = lt_mask;
            end
            VLS_VEQ: begin
                result_o = lt_mask | eq_mask;
            end
            VMIN: begin
                // Equal elements fall through to operand B
                result_o = (operand_A_i & lt_mask) | (operand_B_i & ~lt_mask);
            end
            VMAX: begin
                result_o = (operand_A_i & gt_mask) | (operand_B_i & ~gt_mask);
            end
            default: begin
                // Undefined opcodes give the equal mask
                result_o = eq_mask;
            end
        endcase
    end : result_logic

    // Valid travels alongside the operands with no delay
    assign data_valid_o = data_valid_i;

endmodule : vector_comparison_unit

/* hw/vector_bus_pkg.sv */
// Wishbone request and response structs and the register map

`include "vector_unit_consts.svh"

package vector_bus_pkg;

    // ------------------------------
    // Wishbone classic signals
    // ------------------------------

    // Master side, byte selects are not carried since every access is a full word
    typedef struct packed {
        logic                       cyc;
        logic                       stb;
        logic                       we;
        logic [`VU_ADDR_WIDTH-1:0]  adr;
        logic [`VU_DATA_WIDTH-1:0]  dat;
    } wb_req_t;

    // Slave side
    typedef struct packed {
        logic                       ack;
        logic [`VU_DATA_WIDTH-1:0]  dat;
    } wb_rsp_t;

    // Word addresses of the register map
    typedef enum logic [`VU_ADDR_WIDTH-1:0] {
        REG_OPERAND_A = 3'd0,
        REG_OPERAND_B = 3'd1,
        REG_COMMAND   = 3'd2,
        REG_RESULT    = 3'd3,
        REG_STATUS    = 3'd4
    } vu_reg_e;

endpackage : vector_bus_pkg

/* hw/vector_unit_pkg.sv */
// Vector, element size, compare operation and compare request types

`include "vector_unit_consts.svh"

package vector_unit_pkg;

    // ------------------------------
    // Vector views
    // ------------------------------

    // One 32 bit vector seen either as two halfwords or as four bytes
    typedef union packed {
        logic [1:0][(`VU_DATA_WIDTH/2)-1:0] vect2;
        logic [3:0][(`VU_DATA_WIDTH/4)-1:0] vect4;
    } vector_t;

    // Element size selects how the vector is split
    typedef enum logic {
        BIT8  = 1'b0,
        BIT16 = 1'b1
    } esize_t;

    // ------------------------------
    // Operations and requests
    // ------------------------------

    // Codes 5 to 7 are left undefined and behave like VEQ
    typedef enum logic [2:0] {
        VEQ     = 3'd0,
        VLS     = 3'd1,
        VLS_VEQ = 3'd2,
        VMIN    = 3'd3,
        VMAX    = 3'd4
    } vcomp_operation_t;

    // Everything one queued compare needs
    typedef struct packed {
        vector_t          operand_a;
        vector_t          operand_b;
        vcomp_operation_t operation;
        esize_t           element_size;
        logic             signed_op;
    } vcomp_req_t;

endpackage : vector_unit_pkg

/* hw/vector_unit_consts.svh */
// Data, address and FIFO size macros and command word field positions

`ifndef VECTOR_UNIT_CONSTS_SVH
`define VECTOR_UNIT_CONSTS_SVH

// ------------------------------
// Data path
// ------------------------------

// Width of one vector and of the bus data word
`define VU_DATA_WIDTH 32

// Number of requests the request FIFO holds by default
`define VU_FIFO_DEPTH 4

// ------------------------------
// Bus and command word
// ------------------------------

// Word address width of the register map
`define VU_ADDR_WIDTH 3

// Opcode sits in bits 2 to 0, element size in bit 3 and signedness in bit 4
`define VU_CMD_OP_LSB 0
`define VU_CMD_ESIZE_BIT 3
`define VU_CMD_SIGNED_BIT 4

`endif
